// File: source/rw_gen_pkg.sv
package rw_gen_pkg;

    // --------------------
    // Field types
    // --------------------
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  module_id_t;
    typedef logic [7:0]  seq_t;
    typedef logic [15:0] word_count_t;

    // Module ID stamped on outgoing requests
    localparam module_id_t gen_module_id = 4'd1;

    typedef enum logic [1:0] {
        CMD_MEM_READ = 2'd0,
        CMD_ENGINE   = 2'd1
    } cmd_e;

    typedef enum logic {
        BUF_ENGINE_SETUP = 1'b0,
        BUF_ENGINE_DATA  = 1'b1
    } buffer_e;

    // Job FSM of the decode stage
    typedef enum logic [2:0] {
        DEC_RESET       = 3'd0,
        DEC_IDLE        = 3'd1,
        DEC_SETUP       = 3'd2,
        DEC_WAIT_CONFIG = 3'd3,
        DEC_BUSY        = 3'd4,
        DEC_PAUSE       = 3'd5,
        DEC_DRAIN       = 3'd6,
        DEC_DONE        = 3'd7
    } decode_state_e;

    // --------------------
    // Packets
    // --------------------
    typedef struct packed {
        module_id_t from_id;
        module_id_t to_id;
        seq_t       seq;
    } route_t;

    typedef struct packed {
        data_t   data;
        addr_t   address;
        route_t  route;
        cmd_e    cmd;
        buffer_e buffer;
    } payload_t;

    typedef struct packed {
        logic     valid;
        payload_t payload;
    } packet_t;

    // --------------------
    // Job setup
    // --------------------
    typedef struct packed {
        addr_t      array_pointer;
        logic [1:0] granularity_shift;
        logic       mode_counter;
        module_id_t route_to;
    } config_param_t;

    typedef struct packed {
        logic          valid;
        config_param_t param;
    } config_t;

    typedef struct packed {
        logic        valid;
        word_count_t word_count;
    } descriptor_t;

endpackage

// File: source/rw_sync_fifo.sv
`timescale 1ns/1ps

module rw_sync_fifo #(
    parameter int  FIFO_DEPTH   = 16,
    parameter int  PROG_THRESH  = 8,
    parameter type payload_type = logic [7:0]
) (
    input  logic        ap_clk,
    input  logic        areset_generator,
    input  logic        push,
    input  logic        pop,
    input  payload_type din,
    output payload_type dout,
    output logic        dout_valid,
    output logic        empty,
    output logic        prog_full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_type      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    // Pointer wrap for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    // Writes into a full buffer are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            dout_valid <= 1'b0;
        end
        else begin
            dout_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// File: source/rw_config_decode.sv
`timescale 1ns/1ps

module rw_config_decode (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  rw_gen_pkg::descriptor_t   descriptor,
    input  rw_gen_pkg::config_t       configure_in,
    input  logic                      word_taken,
    input  logic                      request_prog_full,
    input  logic                      drained,
    output logic                      configure_setup,
    output rw_gen_pkg::config_param_t cfg_param,
    output logic                      param_valid,
    output logic                      done
);

    rw_gen_pkg::decode_state_e state;
    rw_gen_pkg::decode_state_e next_state;
    rw_gen_pkg::word_count_t   remaining;
    logic                      last_word;
    logic                      job_start;

    // Final word of the job leaves the engine FIFO
    assign last_word = word_taken & (remaining == rw_gen_pkg::word_count_t'(1));
    assign job_start = descriptor.valid &
                       ((state == rw_gen_pkg::DEC_IDLE) || (state == rw_gen_pkg::DEC_DONE));

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            rw_gen_pkg::DEC_RESET: begin
                next_state = rw_gen_pkg::DEC_IDLE;
            end
            rw_gen_pkg::DEC_IDLE, rw_gen_pkg::DEC_DONE: begin
                if (descriptor.valid) begin
                    next_state = rw_gen_pkg::DEC_SETUP;
                end
            end
            rw_gen_pkg::DEC_SETUP: begin
                next_state = rw_gen_pkg::DEC_WAIT_CONFIG;
            end
            rw_gen_pkg::DEC_WAIT_CONFIG: begin
                // Empty job skips straight to drain
                if (configure_in.valid && remaining == '0) begin
                    next_state = rw_gen_pkg::DEC_DRAIN;
                end
                else if (configure_in.valid) begin
                    next_state = rw_gen_pkg::DEC_BUSY;
                end
            end
            rw_gen_pkg::DEC_BUSY: begin
                if (last_word) begin
                    next_state = rw_gen_pkg::DEC_DRAIN;
                end
                else if (request_prog_full) begin
                    next_state = rw_gen_pkg::DEC_PAUSE;
                end
            end
            rw_gen_pkg::DEC_PAUSE: begin
                // A word may still slip out as prog_full drops
                if (last_word) begin
                    next_state = rw_gen_pkg::DEC_DRAIN;
                end
                else if (!request_prog_full) begin
                    next_state = rw_gen_pkg::DEC_BUSY;
                end
            end
            rw_gen_pkg::DEC_DRAIN: begin
                if (drained) begin
                    next_state = rw_gen_pkg::DEC_DONE;
                end
            end
            default: begin
                next_state = rw_gen_pkg::DEC_IDLE;
            end
        endcase
    end

    // --------------------
    // State and outputs
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state           <= rw_gen_pkg::DEC_RESET;
            configure_setup <= 1'b0;
            param_valid     <= 1'b0;
            done            <= 1'b0;
            cfg_param       <= '0;
        end
        else begin
            state           <= next_state;
            configure_setup <= (next_state == rw_gen_pkg::DEC_SETUP);
            param_valid     <= (next_state == rw_gen_pkg::DEC_BUSY) ||
                               (next_state == rw_gen_pkg::DEC_PAUSE);
            done            <= (next_state == rw_gen_pkg::DEC_DONE);
            if (state == rw_gen_pkg::DEC_WAIT_CONFIG && configure_in.valid) begin
                cfg_param <= configure_in.param;
            end
        end
    end

    // Words still owed by the running job
    always_ff @(posedge ap_clk) begin
        if (job_start) begin
            remaining <= descriptor.word_count;
        end
        else if (word_taken) begin
            remaining <= remaining - 1'b1;
        end
    end

endmodule

// File: source/rw_address_execute.sv
`timescale 1ns/1ps

module rw_address_execute #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  rw_gen_pkg::packet_t       response_engine_in,
    input  rw_gen_pkg::config_param_t cfg_param,
    input  logic                      param_valid,
    input  logic                      request_prog_full,
    output logic                      response_engine_prog_full,
    output logic                      word_taken,
    output logic                      exec_empty,
    output rw_gen_pkg::packet_t       issue
);

    rw_gen_pkg::payload_t word;
    logic                 word_valid;
    logic                 fifo_empty;
    logic                 pop;

    // One word in the stage at a time
    assign pop        = ~fifo_empty & param_valid & ~request_prog_full & ~word_valid;
    assign word_taken = pop;
    assign exec_empty = fifo_empty & ~word_valid & ~issue.valid;

    rw_sync_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH),
        .payload_type(rw_gen_pkg::payload_t)
    ) u_engine_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (response_engine_in.valid),
        .pop             (pop),
        .din             (response_engine_in.payload),
        .dout            (word),
        .dout_valid      (word_valid),
        .empty           (fifo_empty),
        .prog_full       (response_engine_prog_full)
    );

    // --------------------
    // Address kernel
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            issue.valid <= 1'b0;
        end
        else begin
            issue.valid <= word_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        issue.payload.data          <= word.data;
        issue.payload.address       <= cfg_param.array_pointer +
                                       (word.data << cfg_param.granularity_shift);
        issue.payload.route.from_id <= rw_gen_pkg::gen_module_id;
        issue.payload.route.to_id   <= cfg_param.route_to;
        issue.payload.route.seq     <= word.route.seq;
        issue.payload.cmd           <= rw_gen_pkg::CMD_MEM_READ;
        issue.payload.buffer        <= word.buffer;
    end

endmodule

// File: source/rw_request_result.sv
`timescale 1ns/1ps

module rw_request_result #(
    parameter int FIFO_DEPTH    = 16,
    parameter int PROG_THRESH   = 8,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                ap_clk,
    input  logic                areset_generator,
    input  rw_gen_pkg::packet_t issue,
    input  rw_gen_pkg::packet_t response_memory_in,
    input  logic                request_memory_ready,
    input  logic                mode_counter,
    input  logic                exec_empty,
    output rw_gen_pkg::packet_t request_memory_out,
    output rw_gen_pkg::packet_t request_engine_out,
    output logic                request_prog_full,
    output logic                drained
);

    rw_gen_pkg::payload_t     req_dout;
    logic                     req_dout_valid;
    logic                     req_empty;
    logic                     req_pop;
    logic [COUNTER_WIDTH-1:0] outstanding;
    logic                     outstanding_zero;
    rw_gen_pkg::payload_t     relabel;

    // --------------------
    // Request queue
    // --------------------
    assign req_pop = request_memory_ready & ~req_empty;

    rw_sync_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH),
        .payload_type(rw_gen_pkg::payload_t)
    ) u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (issue.valid),
        .pop             (req_pop),
        .din             (issue.payload),
        .dout            (req_dout),
        .dout_valid      (req_dout_valid),
        .empty           (req_empty),
        .prog_full       (request_prog_full)
    );

    assign request_memory_out = '{valid: req_dout_valid, payload: req_dout};

    // Requests issued minus responses forwarded
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end
        else begin
            case ({request_memory_out.valid, request_engine_out.valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign outstanding_zero = (outstanding == '0);

    // A word on its way out of the queue still counts as pending
    assign drained = req_empty & ~req_dout_valid & exec_empty &
                     (~mode_counter | outstanding_zero);

    // --------------------
    // Response relabelling
    // --------------------
    always_comb begin
        relabel     = response_memory_in.payload;
        relabel.cmd = rw_gen_pkg::CMD_ENGINE;
        if (response_memory_in.payload.route.to_id == rw_gen_pkg::gen_module_id) begin
            relabel.buffer = rw_gen_pkg::BUF_ENGINE_SETUP;
        end
        else begin
            relabel.buffer = rw_gen_pkg::BUF_ENGINE_DATA;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_engine_out.valid <= 1'b0;
        end
        else begin
            request_engine_out.valid <= response_memory_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_engine_out.payload <= relabel;
    end

endmodule

// File: source/rw_generator_top.sv
`timescale 1ns/1ps

module rw_generator_top #(
    parameter int FIFO_DEPTH    = 16,
    parameter int PROG_THRESH   = 8,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  rw_gen_pkg::descriptor_t descriptor_in,
    output logic                    configure_setup,
    input  rw_gen_pkg::config_t     configure_in,
    input  rw_gen_pkg::packet_t     response_engine_in,
    output logic                    response_engine_prog_full,
    output rw_gen_pkg::packet_t     request_memory_out,
    input  logic                    request_memory_ready,
    input  rw_gen_pkg::packet_t     response_memory_in,
    output rw_gen_pkg::packet_t     request_engine_out,
    output logic                    done
);

    rw_gen_pkg::descriptor_t   descriptor_reg;
    rw_gen_pkg::config_t       configure_reg;
    rw_gen_pkg::packet_t       response_engine_reg;
    rw_gen_pkg::packet_t       response_memory_reg;
    logic                      ready_reg;

    rw_gen_pkg::config_param_t cfg_param;
    rw_gen_pkg::packet_t       issue;
    logic                      param_valid;
    logic                      word_taken;
    logic                      exec_empty;
    logic                      request_prog_full;
    logic                      drained;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            descriptor_reg.valid      <= 1'b0;
            configure_reg.valid       <= 1'b0;
            response_engine_reg.valid <= 1'b0;
            response_memory_reg.valid <= 1'b0;
            ready_reg                 <= 1'b0;
        end
        else begin
            descriptor_reg.valid      <= descriptor_in.valid;
            configure_reg.valid       <= configure_in.valid;
            response_engine_reg.valid <= response_engine_in.valid;
            response_memory_reg.valid <= response_memory_in.valid;
            ready_reg                 <= request_memory_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_reg.word_count   <= descriptor_in.word_count;
        configure_reg.param         <= configure_in.param;
        response_engine_reg.payload <= response_engine_in.payload;
        response_memory_reg.payload <= response_memory_in.payload;
    end

    // --------------------
    // Decode, execute, result
    // --------------------
    rw_config_decode u_decode (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor       (descriptor_reg),
        .configure_in     (configure_reg),
        .word_taken       (word_taken),
        .request_prog_full(request_prog_full),
        .drained          (drained),
        .configure_setup  (configure_setup),
        .cfg_param        (cfg_param),
        .param_valid      (param_valid),
        .done             (done)
    );

    rw_address_execute #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_execute (
        .ap_clk                   (ap_clk),
        .areset_generator         (areset_generator),
        .response_engine_in       (response_engine_reg),
        .cfg_param                (cfg_param),
        .param_valid              (param_valid),
        .request_prog_full        (request_prog_full),
        .response_engine_prog_full(response_engine_prog_full),
        .word_taken               (word_taken),
        .exec_empty               (exec_empty),
        .issue                    (issue)
    );

    rw_request_result #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .PROG_THRESH  (PROG_THRESH),
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) u_result (
        .ap_clk              (ap_clk),
        .areset_generator    (areset_generator),
        .issue               (issue),
        .response_memory_in  (response_memory_reg),
        .request_memory_ready(ready_reg),
        .mode_counter        (cfg_param.mode_counter),
        .exec_empty          (exec_empty),
        .request_memory_out  (request_memory_out),
        .request_engine_out  (request_engine_out),
        .request_prog_full   (request_prog_full),
        .drained             (drained)
    );

endmodule

// File: tests/rw_generator_checker.sv
`timescale 1ns/1ps

module rw_generator_checker (
    input logic ap_clk,
    input logic areset_generator,
    input logic configure_setup,
    input logic done,
    input logic mode_counter,
    input logic request_memory_valid,
    input logic request_engine_valid
);

    // Requests out minus responses back
    logic [15:0] in_flight;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            in_flight <= '0;
        end
        else if (request_memory_valid && !request_engine_valid) begin
            in_flight <= in_flight + 16'd1;
        end
        else if (!request_memory_valid && request_engine_valid) begin
            in_flight <= in_flight - 16'd1;
        end
    end

    setup_single_pulse: assert property (@(posedge ap_clk) disable iff (areset_generator)
        configure_setup |=> !configure_setup)
        else $error("configure_setup high for more than one cycle");

    done_only_when_drained: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (done && mode_counter) |-> (in_flight == '0))
        else $error("done high with %0d requests outstanding", in_flight);

    // Outputs settle low from the first reset edge on
    quiet_during_reset: assert property (@(posedge ap_clk)
        areset_generator |=> !(request_memory_valid || request_engine_valid ||
                               configure_setup || done))
        else $error("output strobe high during reset");

endmodule

bind rw_generator_top rw_generator_checker u_checker (
    .ap_clk              (ap_clk),
    .areset_generator    (areset_generator),
    .configure_setup     (configure_setup),
    .done                (done),
    .mode_counter        (cfg_param.mode_counter),
    .request_memory_valid(request_memory_out.valid),
    .request_engine_valid(request_engine_out.valid)
);

// File: tests/rw_generator_tb.sv
`timescale 1ns/1ps

module rw_generator_tb;

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_JOBS       = 5;
    localparam int MAX_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * MAX_WORDS * 40 + 2000;

    logic                    ap_clk;
    logic                    areset_generator;
    rw_gen_pkg::descriptor_t descriptor_in;
    logic                    configure_setup;
    rw_gen_pkg::config_t     configure_in;
    rw_gen_pkg::packet_t     response_engine_in;
    logic                    response_engine_prog_full;
    rw_gen_pkg::packet_t     request_memory_out;
    logic                    request_memory_ready;
    rw_gen_pkg::packet_t     response_memory_in;
    rw_gen_pkg::packet_t     request_engine_out;
    logic                    done;

    int unsigned cycle_count;
    int unsigned mismatch_count;
    int unsigned failure_count;
    int unsigned requests_seen;
    int unsigned responses_seen;

    // Expected requests, and requests waiting in the memory model
    rw_gen_pkg::payload_t expected_requests[$];
    rw_gen_pkg::payload_t memory_payloads[$];
    int unsigned          memory_due[$];

    rw_generator_top #(
        .FIFO_DEPTH   (16),
        .PROG_THRESH  (8),
        .COUNTER_WIDTH(16)
    ) UUT (
        .ap_clk                   (ap_clk),
        .areset_generator         (areset_generator),
        .descriptor_in            (descriptor_in),
        .configure_setup          (configure_setup),
        .configure_in             (configure_in),
        .response_engine_in       (response_engine_in),
        .response_engine_prog_full(response_engine_prog_full),
        .request_memory_out       (request_memory_out),
        .request_memory_ready     (request_memory_ready),
        .response_memory_in       (response_memory_in),
        .request_engine_out       (request_engine_out),
        .done                     (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic rw_gen_pkg::payload_t expected_request(
        input rw_gen_pkg::payload_t      word,
        input rw_gen_pkg::config_param_t param
    );
        rw_gen_pkg::payload_t req;
        req               = word;
        req.address       = param.array_pointer + (word.data << param.granularity_shift);
        req.route.from_id = rw_gen_pkg::gen_module_id;
        req.route.to_id   = param.route_to;
        req.cmd           = rw_gen_pkg::CMD_MEM_READ;
        return req;
    endfunction

    // Responses addressed to this generator go to the setup buffer
    function automatic rw_gen_pkg::packet_t relabeled_response(input rw_gen_pkg::payload_t resp);
        rw_gen_pkg::packet_t pkt;
        pkt.valid       = 1'b1;
        pkt.payload     = resp;
        pkt.payload.cmd = rw_gen_pkg::CMD_ENGINE;
        if (resp.route.to_id == rw_gen_pkg::gen_module_id) begin
            pkt.payload.buffer = rw_gen_pkg::BUF_ENGINE_SETUP;
        end
        else begin
            pkt.payload.buffer = rw_gen_pkg::BUF_ENGINE_DATA;
        end
        return pkt;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        failure_count++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    // --------------------
    // One job
    // --------------------
    task automatic run_job(input int job);
        rw_gen_pkg::word_count_t   count;
        rw_gen_pkg::config_param_t param;
        rw_gen_pkg::payload_t      word;
        int unsigned               delay;
        count                   = 16'($urandom_range(1, MAX_WORDS));
        param.array_pointer     = $urandom;
        param.granularity_shift = 2'($urandom_range(0, 3));
        param.mode_counter      = (job < 2) ? (job == 0) : 1'($urandom_range(0, 1));
        // Even jobs aim back at this generator, odd jobs elsewhere
        param.route_to = (job % 2 == 0) ? rw_gen_pkg::gen_module_id :
                                          4'($urandom_range(2, 15));
        requests_seen  = 0;
        responses_seen = 0;

        descriptor_in = '{valid: 1'b1, word_count: count};
        @(negedge ap_clk);
        descriptor_in.valid = 1'b0;
        while (!configure_setup) begin
            @(negedge ap_clk);
        end
        delay = $urandom_range(0, 3);
        repeat (delay) @(negedge ap_clk);
        configure_in = '{valid: 1'b1, param: param};
        @(negedge ap_clk);
        configure_in.valid = 1'b0;

        for (int i = 0; i < int'(count); i++) begin
            while (response_engine_prog_full || $urandom_range(0, 3) == 0) begin
                response_engine_in.valid = 1'b0;
                @(negedge ap_clk);
            end
            word.data          = $urandom;
            word.address       = $urandom;
            word.route.from_id = 4'($urandom);
            word.route.to_id   = 4'($urandom);
            word.route.seq     = 8'(i);
            word.cmd           = rw_gen_pkg::CMD_ENGINE;
            word.buffer        = rw_gen_pkg::buffer_e'($urandom_range(0, 1));
            response_engine_in = '{valid: 1'b1, payload: word};
            expected_requests.push_back(expected_request(word, param));
            @(negedge ap_clk);
        end
        response_engine_in.valid = 1'b0;

        while (!done) begin
            @(negedge ap_clk);
        end
        if (requests_seen != count) begin
            report_failure($sformatf("job %0d done after %0d of %0d requests",
                                     job, requests_seen, count));
        end
        if (param.mode_counter && responses_seen != count) begin
            report_failure($sformatf("job %0d done after %0d of %0d responses in counter mode",
                                     job, responses_seen, count));
        end
        // Let the memory model finish before the next job
        while (responses_seen < count) begin
            @(negedge ap_clk);
        end
        if (expected_requests.size() != 0) begin
            report_failure($sformatf("job %0d left %0d requests never issued",
                                     job, expected_requests.size()));
            expected_requests.delete();
        end
        repeat (3) @(negedge ap_clk);
    endtask

    initial begin
        int unsigned seed_value;
        seed_value         = $urandom(20);
        areset_generator   = 1'b1;
        descriptor_in      = '0;
        configure_in       = '0;
        response_engine_in = '0;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;
        repeat (2) @(negedge ap_clk);
        for (int job = 0; job < NUM_JOBS; job++) begin
            run_job(job);
        end
        $display("Errors: %0d mismatches, %0d other failures over %0d jobs",
                 mismatch_count, failure_count, NUM_JOBS);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // --------------------
    // Memory model and output checks
    // --------------------
    initial begin
        rw_gen_pkg::packet_t  engine_pipe [2];
        rw_gen_pkg::packet_t  response;
        rw_gen_pkg::payload_t expected;
        int unsigned          ready_left;
        int unsigned          due;
        int unsigned          last_due;
        request_memory_ready = 1'b0;
        response_memory_in   = '0;
        engine_pipe[0]       = '0;
        engine_pipe[1]       = '0;
        ready_left           = 0;
        last_due             = 0;
        forever begin
            @(negedge ap_clk);
            if (cycle_count > RESET_CYCLES) begin
                // Response strobed two cycles back
                if (engine_pipe[1].valid) begin
                    responses_seen++;
                    if (!request_engine_out.valid) begin
                        report_mismatch("no packet on request_engine_out");
                    end
                    else if (request_engine_out.payload !== engine_pipe[1].payload) begin
                        report_mismatch($sformatf("engine packet %h, expected %h",
                            request_engine_out.payload, engine_pipe[1].payload));
                    end
                end
                else if (request_engine_out.valid) begin
                    report_failure("request_engine_out valid without a memory response");
                end

                if (request_memory_out.valid) begin
                    requests_seen++;
                    if (expected_requests.size() == 0) begin
                        report_failure("request_memory_out valid with no engine word pending");
                    end
                    else begin
                        expected = expected_requests.pop_front();
                        if (request_memory_out.payload !== expected) begin
                            report_mismatch($sformatf("memory request %h, expected %h",
                                request_memory_out.payload, expected));
                        end
                    end
                    due = cycle_count + $urandom_range(1, 8);
                    last_due = (due > last_due) ? due : last_due;
                    memory_payloads.push_back(request_memory_out.payload);
                    memory_due.push_back(last_due);
                end

                response = '0;
                if (memory_payloads.size() != 0 && memory_due[0] <= cycle_count) begin
                    response.valid   = 1'b1;
                    response.payload = memory_payloads.pop_front();
                    due              = memory_due.pop_front();
                end
                response_memory_in = response;
                engine_pipe[1]     = engine_pipe[0];
                engine_pipe[0]     = response.valid ? relabeled_response(response.payload) : '0;

                // Ready in random stretches
                if (ready_left == 0) begin
                    request_memory_ready = ($urandom_range(0, 2) != 0);
                    ready_left           = $urandom_range(1, 16);
                end
                ready_left--;
            end
        end
    end

    // Watchdog
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures, run timed out",
                 mismatch_count, failure_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: files.f
source/rw_gen_pkg.sv
source/rw_sync_fifo.sv
source/rw_config_decode.sv
source/rw_address_execute.sv
source/rw_request_result.sv
source/rw_generator_top.sv
tests/rw_generator_checker.sv
tests/rw_generator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the request generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rw_generator_tb -f files.f -o rw_generator_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rw_generator_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0
